//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
	-f src.f --top-module tb_exec_core -o sim_exec_core
./obj_dir/sim_exec_core | tee sim.log
if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- source/alu.sv
`timescale 1ns/10ps

module alu
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input logic [alu_op_width-1:0] alu_op,
	input logic [xlen-1:0] op_a,
	input logic [xlen-1:0] op_b,
	input logic [reg_id_width-1:0] rd_id,
	input logic rd_vld,
	input logic is_long, // result comes from muldiv
	input logic [inst_id_width-1:0] inst_id,
	input logic illegal,
	output logic res_valid,
	input logic res_ready,
	output logic [reg_id_width-1:0] res_rd_id,
	output logic [xlen-1:0] res_data,
	output logic [inst_id_width-1:0] res_inst_id,
	output logic res_illegal
);
	logic [xlen-1:0] result;
	logic [4:0] shamt;

	assign shamt = op_b[4:0];
	assign req_ready = ~res_valid | res_ready; // empty or draining

	always_comb begin
		case (alu_op)
			alu_op_add: result = op_a + op_b;
			alu_op_sub: result = op_a - op_b;
			alu_op_sll: result = op_a << shamt;
			alu_op_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_op_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
			alu_op_xor: result = op_a ^ op_b;
			alu_op_srl: result = op_a >> shamt;
			alu_op_sra: result = $unsigned($signed(op_a) >>> shamt);
			alu_op_or: result = op_a | op_b;
			alu_op_and: result = op_a & op_b;
			alu_op_pass2: result = op_b; // lui value or illegal word
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else if (req_ready)
			res_valid <= req_valid & rd_vld & ~is_long; // long and x0 only retire
	end

	always_ff @(posedge clk) begin
		if (req_valid & req_ready) begin
			res_rd_id <= rd_id;
			res_data <= result;
			res_inst_id <= inst_id;
			res_illegal <= illegal;
		end
	end
endmodule

//--- source/dispatcher.sv
`timescale 1ns/10ps

module dispatcher
	import exec_pkg::*;
(
	input logic clk, // assertions only
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input logic [inst_id_width-1:0] inst_id,
	input logic [alu_op_width-1:0] alu_op,
	input logic [xlen-1:0] op_a,
	input logic [xlen-1:0] op_b,
	input logic is_muldiv,
	input logic [md_op_width-1:0] md_op,
	input logic [reg_id_width-1:0] rd_id,
	input logic rd_vld,
	input logic illegal,
	output logic [reg_id_width-1:0] waw_check_rd_id,
	input logic rd_waw, // rd still pending
	output logic issue_fire,
	output logic [reg_id_width-1:0] issue_rd_id,
	output logic alu_valid,
	input logic alu_ready,
	output logic alu_is_long,
	output logic [alu_op_width-1:0] req_alu_op,
	output logic [xlen-1:0] req_op_a,
	output logic [xlen-1:0] req_op_b,
	output logic [reg_id_width-1:0] req_rd_id,
	output logic req_rd_vld,
	output logic [inst_id_width-1:0] req_inst_id,
	output logic req_illegal,
	output logic md_valid,
	input logic md_ready,
	output logic [md_op_width-1:0] req_md_op
);
	logic waw_hazard;
	logic md_needed; // muldiv unit joins this issue
	logic both_ready; // alu and muldiv can both take it

	assign waw_check_rd_id = rd_id;
	assign waw_hazard = rd_vld & rd_waw;
	assign md_needed = is_muldiv & rd_vld; // mul to x0 just retires in the alu
	assign both_ready = alu_ready & md_ready;

	// every instruction goes through the alu, muldiv ones also need the unit
	assign inst_ready = ~waw_hazard & alu_ready & (~md_needed | md_ready);
	assign alu_valid = inst_valid & ~waw_hazard & (~md_needed | both_ready);
	assign md_valid = inst_valid & ~waw_hazard & md_needed & both_ready; // paired transfer
	assign issue_fire = inst_valid & inst_ready & rd_vld; // marks rd pending
	assign issue_rd_id = rd_id;

	assign alu_is_long = is_muldiv; // alu result is not written back
	assign req_alu_op = alu_op;
	assign req_op_a = op_a;
	assign req_op_b = op_b;
	assign req_rd_id = rd_id;
	assign req_rd_vld = rd_vld;
	assign req_inst_id = inst_id;
	assign req_illegal = illegal;
	assign req_md_op = md_op;

	// muldiv never starts without its alu slot
	a_md_with_alu: assert property (@(posedge clk) disable iff (reset)
		md_valid |-> alu_valid);
	// offered requests stay up until taken
	a_alu_hold: assert property (@(posedge clk) disable iff (reset)
		alu_valid && !alu_ready |=> alu_valid);
endmodule

//--- source/exec_core_top.sv
`timescale 1ns/10ps

module exec_core_top
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [31:0] inst,
	input logic [xlen-1:0] rs1_val,
	input logic [xlen-1:0] rs2_val,
	input logic [inst_id_width-1:0] inst_id,
	input logic inst_valid,
	output logic inst_ready,
	output logic wb_valid,
	output logic [reg_id_width-1:0] wb_rd_id,
	output logic [xlen-1:0] wb_data,
	output logic [inst_id_width-1:0] wb_inst_id,
	output logic wb_illegal
);
	logic [xlen-1:0] op_a; // decoded fields
	logic [xlen-1:0] op_b;
	logic [alu_op_width-1:0] alu_op;
	logic is_muldiv;
	logic [md_op_width-1:0] md_op;
	logic [reg_id_width-1:0] rd_id;
	logic rd_vld;
	logic illegal;
	logic [reg_id_width-1:0] waw_check_rd_id; // scoreboard lookup
	logic rd_waw;
	logic issue_fire;
	logic [reg_id_width-1:0] issue_rd_id;
	logic alu_valid; // unit requests
	logic alu_ready;
	logic alu_is_long;
	logic md_valid;
	logic md_ready;
	logic [alu_op_width-1:0] req_alu_op;
	logic [xlen-1:0] req_op_a;
	logic [xlen-1:0] req_op_b;
	logic [reg_id_width-1:0] req_rd_id;
	logic req_rd_vld;
	logic [inst_id_width-1:0] req_inst_id;
	logic req_illegal;
	logic [md_op_width-1:0] req_md_op;
	logic alu_res_valid; // unit results
	logic alu_res_ready;
	logic [reg_id_width-1:0] alu_res_rd_id;
	logic [xlen-1:0] alu_res_data;
	logic [inst_id_width-1:0] alu_res_inst_id;
	logic alu_res_illegal;
	logic md_res_valid;
	logic md_res_ready;
	logic [reg_id_width-1:0] md_res_rd_id;
	logic [xlen-1:0] md_res_data;
	logic [inst_id_width-1:0] md_res_inst_id;

	inst_decoder u_decoder (.*); // names line up one to one

	dispatcher u_dispatcher (.*);

	alu u_alu (
		.clk(clk), .reset(reset),
		.req_valid(alu_valid), .req_ready(alu_ready),
		.alu_op(req_alu_op), .op_a(req_op_a), .op_b(req_op_b),
		.rd_id(req_rd_id), .rd_vld(req_rd_vld), .is_long(alu_is_long),
		.inst_id(req_inst_id), .illegal(req_illegal),
		.res_valid(alu_res_valid), .res_ready(alu_res_ready),
		.res_rd_id(alu_res_rd_id), .res_data(alu_res_data),
		.res_inst_id(alu_res_inst_id), .res_illegal(alu_res_illegal)
	);

	muldiv_unit u_muldiv (
		.clk(clk), .reset(reset),
		.req_valid(md_valid), .req_ready(md_ready),
		.md_op(req_md_op), .op_a(req_op_a), .op_b(req_op_b),
		.rd_id(req_rd_id), .inst_id(req_inst_id),
		.res_valid(md_res_valid), .res_ready(md_res_ready),
		.res_rd_id(md_res_rd_id), .res_data(md_res_data),
		.res_inst_id(md_res_inst_id)
	);

	result_commit u_commit (.*);
endmodule

//--- source/exec_pkg.sv
package exec_pkg;
	localparam int inst_id_width = 4; // tag from fetch
	localparam int reg_id_width = 5; // x0..x31
	localparam int xlen = 32;

	localparam int alu_op_width = 4;
	localparam logic [alu_op_width-1:0] alu_op_add = 4'd0;
	localparam logic [alu_op_width-1:0] alu_op_sub = 4'd1;
	localparam logic [alu_op_width-1:0] alu_op_sll = 4'd2;
	localparam logic [alu_op_width-1:0] alu_op_slt = 4'd3; // signed compare
	localparam logic [alu_op_width-1:0] alu_op_sltu = 4'd4;
	localparam logic [alu_op_width-1:0] alu_op_xor = 4'd5;
	localparam logic [alu_op_width-1:0] alu_op_srl = 4'd6;
	localparam logic [alu_op_width-1:0] alu_op_sra = 4'd7;
	localparam logic [alu_op_width-1:0] alu_op_or = 4'd8;
	localparam logic [alu_op_width-1:0] alu_op_and = 4'd9;
	localparam logic [alu_op_width-1:0] alu_op_pass2 = 4'd10; // lui, illegal word

	localparam int md_op_width = 3; // same as funct3
	localparam logic [md_op_width-1:0] md_op_mul = 3'b000;
	localparam logic [md_op_width-1:0] md_op_mulh = 3'b001;
	localparam logic [md_op_width-1:0] md_op_mulhsu = 3'b010;
	localparam logic [md_op_width-1:0] md_op_mulhu = 3'b011;
	localparam logic [md_op_width-1:0] md_op_div = 3'b100;
	localparam logic [md_op_width-1:0] md_op_divu = 3'b101;
	localparam logic [md_op_width-1:0] md_op_rem = 3'b110;
	localparam logic [md_op_width-1:0] md_op_remu = 3'b111;

	localparam logic [6:0] opc_op = 7'b0110011; // register-register
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;

	localparam int md_steps = 32; // one bit per iteration
endpackage

//--- source/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder
	import exec_pkg::*;
(
	input logic [31:0] inst, // raw word
	input logic [xlen-1:0] rs1_val,
	input logic [xlen-1:0] rs2_val,
	output logic [xlen-1:0] op_a,
	output logic [xlen-1:0] op_b, // rs2, immediate or the word itself
	output logic [alu_op_width-1:0] alu_op,
	output logic is_muldiv,
	output logic [md_op_width-1:0] md_op,
	output logic [reg_id_width-1:0] rd_id,
	output logic rd_vld, // low for x0
	output logic illegal
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] imm_i; // sign-extended i-type immediate

	// funct3 to alu op, alt picks sub/sra
	function automatic logic [alu_op_width-1:0] base_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: base_op = alt ? alu_op_sub : alu_op_add;
			3'b001: base_op = alu_op_sll;
			3'b010: base_op = alu_op_slt;
			3'b011: base_op = alu_op_sltu;
			3'b100: base_op = alu_op_xor;
			3'b101: base_op = alt ? alu_op_sra : alu_op_srl;
			3'b110: base_op = alu_op_or;
			default: base_op = alu_op_and;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};

	assign op_a = rs1_val;
	assign rd_id = inst[11:7];
	assign md_op = funct3; // m-extension funct3 is the op code
	assign rd_vld = illegal | (rd_id != '0); // illegal word always writes back

	always_comb begin
		alu_op = alu_op_add;
		op_b = rs2_val;
		is_muldiv = 1'b0;
		illegal = 1'b0;
		case (opcode)
			opc_op: begin
				if (funct7 == 7'b0000001)
					is_muldiv = 1'b1; // mul/div/rem
				else if (funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
					alu_op = base_op(funct3, funct7[5]);
				else
					illegal = 1'b1;
			end
			opc_op_imm: begin
				op_b = imm_i;
				alu_op = base_op(funct3, funct3 == 3'b101 && funct7[5]); // addi has no sub
				if (funct3 == 3'b001 && funct7 != 7'b0000000)
					illegal = 1'b1; // bad slli
				if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)
					illegal = 1'b1; // bad srli/srai
			end
			opc_lui: begin
				alu_op = alu_op_pass2;
				op_b = {inst[31:12], 12'b0};
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			alu_op = alu_op_pass2;
			op_b = inst; // word itself becomes the result
			is_muldiv = 1'b0;
		end
	end
endmodule

//--- source/muldiv_unit.sv
`timescale 1ns/10ps

module muldiv_unit
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input logic [md_op_width-1:0] md_op,
	input logic [xlen-1:0] op_a,
	input logic [xlen-1:0] op_b,
	input logic [reg_id_width-1:0] rd_id,
	input logic [inst_id_width-1:0] inst_id,
	output logic res_valid,
	input logic res_ready,
	output logic [reg_id_width-1:0] res_rd_id,
	output logic [xlen-1:0] res_data,
	output logic [inst_id_width-1:0] res_inst_id
);
	logic busy; // from transfer until result taken
	logic [$clog2(md_steps+1)-1:0] cnt; // steps left
	logic [md_op_width-1:0] op_q;
	logic neg; // negate the final magnitude
	logic [xlen-1:0] hi; // product high half or partial remainder
	logic [xlen-1:0] lo; // multiplier/dividend, ends as product low or quotient
	logic [xlen-1:0] mcand; // multiplicand or divisor magnitude
	logic sign_a; // negative signed operand a
	logic sign_b;
	logic [xlen:0] mul_sum;
	logic [xlen:0] div_shift; // remainder shifted with next dividend bit
	logic [xlen+1:0] div_diff; // msb is the borrow
	logic [2*xlen-1:0] prod;
	logic [xlen-1:0] final_res;

	assign req_ready = ~busy;
	assign sign_a = op_a[xlen-1] & (md_op inside {md_op_mulh, md_op_mulhsu, md_op_div, md_op_rem});
	assign sign_b = op_b[xlen-1] & (md_op inside {md_op_mulh, md_op_div, md_op_rem});

	assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, mcand} : '0);
	assign div_shift = {hi, lo[xlen-1]};
	assign div_diff = {1'b0, div_shift} - {2'b0, mcand};
	assign prod = neg ? -{hi, lo} : {hi, lo};

	always_comb begin
		case (op_q)
			md_op_mul: final_res = prod[xlen-1:0];
			md_op_mulh, md_op_mulhsu, md_op_mulhu: final_res = prod[2*xlen-1:xlen];
			md_op_div, md_op_divu: final_res = neg ? -lo : lo;
			default: final_res = neg ? -hi : hi; // rem keeps dividend sign
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
			res_valid <= 1'b0;
		end else if (req_valid & req_ready) begin
			busy <= 1'b1;
			cnt <= md_steps[$bits(cnt)-1:0];
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else if (busy & ~res_valid) begin
			res_valid <= 1'b1; // one cycle for sign fix
		end else if (res_valid & res_ready) begin
			res_valid <= 1'b0;
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid & req_ready) begin
			op_q <= md_op;
			res_rd_id <= rd_id;
			res_inst_id <= inst_id;
			hi <= '0;
			lo <= sign_a ? -op_a : op_a;
			mcand <= sign_b ? -op_b : op_b;
			if (md_op == md_op_div)
				neg <= (sign_a ^ sign_b) & (op_b != '0); // x/0 stays all ones
			else if (md_op == md_op_rem)
				neg <= sign_a;
			else
				neg <= sign_a ^ sign_b; // zero for unsigned ops
		end else if (cnt != '0) begin
			if (op_q[2]) begin // restoring divide step
				hi <= div_diff[xlen+1] ? div_shift[xlen-1:0] : div_diff[xlen-1:0];
				lo <= {lo[xlen-2:0], ~div_diff[xlen+1]};
			end else begin // shift-add multiply step
				hi <= mul_sum[xlen:1];
				lo <= {mul_sum[0], lo[xlen-1:1]};
			end
		end else if (busy & ~res_valid) begin
			res_data <= final_res;
		end
	end

	a_no_early_result: assert property (@(posedge clk) disable iff (reset)
		cnt != '0 |-> !res_valid);
endmodule

//--- source/result_commit.sv
`timescale 1ns/10ps

module result_commit
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [reg_id_width-1:0] waw_check_rd_id,
	output logic rd_waw,
	input logic issue_fire,
	input logic [reg_id_width-1:0] issue_rd_id,
	input logic alu_res_valid,
	output logic alu_res_ready,
	input logic [reg_id_width-1:0] alu_res_rd_id,
	input logic [xlen-1:0] alu_res_data,
	input logic [inst_id_width-1:0] alu_res_inst_id,
	input logic alu_res_illegal,
	input logic md_res_valid,
	output logic md_res_ready,
	input logic [reg_id_width-1:0] md_res_rd_id,
	input logic [xlen-1:0] md_res_data,
	input logic [inst_id_width-1:0] md_res_inst_id,
	output logic wb_valid, // one-cycle strobe
	output logic [reg_id_width-1:0] wb_rd_id,
	output logic [xlen-1:0] wb_data,
	output logic [inst_id_width-1:0] wb_inst_id,
	output logic wb_illegal
);
	logic [2**reg_id_width-1:0] pending; // rd awaiting writeback
	logic win_valid;
	logic [reg_id_width-1:0] win_rd_id;

	assign rd_waw = pending[waw_check_rd_id];
	assign md_res_ready = 1'b1; // muldiv always wins
	assign alu_res_ready = ~md_res_valid;
	assign win_valid = md_res_valid | alu_res_valid;
	assign win_rd_id = md_res_valid ? md_res_rd_id : alu_res_rd_id;

	// set and clear never hit the same rd, issue needs it idle
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= win_valid;
			if (win_valid)
				pending[win_rd_id] <= 1'b0;
			if (issue_fire)
				pending[issue_rd_id] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			wb_rd_id <= win_rd_id;
			wb_data <= md_res_valid ? md_res_data : alu_res_data;
			wb_inst_id <= md_res_valid ? md_res_inst_id : alu_res_inst_id;
			wb_illegal <= ~md_res_valid & alu_res_illegal; // muldiv is never illegal
		end
	end

	a_wb_pending: assert property (@(posedge clk) disable iff (reset)
		win_valid |-> pending[win_rd_id]);
	a_issue_idle: assert property (@(posedge clk) disable iff (reset)
		issue_fire |-> !pending[issue_rd_id]);
endmodule

//--- src.f
source/exec_pkg.sv
source/inst_decoder.sv
source/dispatcher.sv
source/alu.sv
source/muldiv_unit.sv
source/result_commit.sv
source/exec_core_top.sv
testbench/tb_exec_core.sv

//--- testbench/tb_exec_core.sv
`timescale 1ns/10ps

module tb_exec_core
	import exec_pkg::*;
;
	localparam int wait_limit = 200; // cycles, a few chained muldiv ops at most
	localparam int random_count = 400;

	logic clk;
	logic reset;
	logic [31:0] inst;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic [inst_id_width-1:0] inst_id;
	logic inst_valid;
	logic inst_ready;
	logic wb_valid;
	logic [reg_id_width-1:0] wb_rd_id;
	logic [xlen-1:0] wb_data;
	logic [inst_id_width-1:0] wb_inst_id;
	logic wb_illegal;

	logic exp_valid [16]; // expected writebacks by tag
	logic [reg_id_width-1:0] exp_rd [16];
	logic [xlen-1:0] exp_data [16];
	logic exp_illegal [16];
	logic [inst_id_width-1:0] order_q [32][$]; // issue order per rd
	logic [inst_id_width-1:0] issue_q [$]; // issue order overall
	logic [inst_id_width-1:0] next_tag;
	int md_stalls = 0; // cycles a muldiv word waited
	int overtakes = 0; // writebacks ahead of an older one
	int wb_count = 0;

	exec_core_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	task automatic stop_with_fail(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_fail($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd);
		return {f7, 5'd2, 5'd1, f3, rd, opc_op}; // rs fields unused, values come in beside
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd);
		return {imm, 5'd1, f3, rd, opc_op_imm};
	endfunction

	// m extension, 64 bit product and truncating division
	function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		ea = {{32{a[31] & (f3 == 3'd1 || f3 == 3'd2)}}, a}; // mulh, mulhsu signed a
		eb = {{32{b[31] & (f3 == 3'd1)}}, b}; // only mulh signed b
		p = ea * eb;
		sa = a;
		sb = b;
		if (f3 == 3'd0)
			return p[31:0];
		if (f3 < 3'd4)
			return p[63:32];
		if (b == 32'h0)
			return f3[1] ? a : 32'hffff_ffff; // divide by zero
		if (!f3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff)
			return f3[1] ? 32'h0 : a; // signed overflow
		if (f3 == 3'd4)
			return sa / sb;
		if (f3 == 3'd5)
			return a / b;
		if (f3 == 3'd6)
			return sa % sb;
		return a % b;
	endfunction

	// rv32im slice reference, returns {illegal, data}
	function automatic logic [32:0] expected_result(input logic [31:0] word,
		input logic [31:0] a, input logic [31:0] b);
		logic [6:0] f7;
		logic [2:0] f3;
		logic [31:0] rhs;
		logic [31:0] data;
		logic [4:0] sh;
		logic bad;
		f7 = word[31:25];
		f3 = word[14:12];
		rhs = b;
		bad = 1'b0;
		if (word[6:0] == opc_lui)
			return {1'b0, word[31:12], 12'h000};
		if (word[6:0] == opc_op && f7 == 7'h01)
			return {1'b0, muldiv_ref(f3, a, b)};
		if (word[6:0] == opc_op)
			bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
		else if (word[6:0] == opc_op_imm) begin
			rhs = {{20{word[31]}}, word[31:20]};
			bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
		end else
			bad = 1'b1;
		if (bad)
			return {1'b1, word}; // word itself is the result
		sh = rhs[4:0];
		case (f3)
			3'd0: data = (word[6:0] == opc_op && f7[5]) ? a - rhs : a + rhs; // no subi
			3'd1: data = a << sh;
			3'd2: data = {31'd0, $signed(a) < $signed(rhs)};
			3'd3: data = {31'd0, a < rhs};
			3'd4: data = a ^ rhs;
			3'd5: begin
				data = a >> sh;
				if (f7[5])
					data = $signed(a) >>> sh; // sra, srai
			end
			3'd6: data = a | rhs;
			default: data = a & rhs;
		endcase
		return {1'b0, data};
	endfunction

	function automatic logic [31:0] pick_operand();
		case ($urandom % 8)
			0: return 32'h0;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000; // most negative
			3: return $urandom % 16;
			default: return $urandom;
		endcase
	endfunction

	task automatic random_inst(output logic [31:0] word);
		logic [2:0] f3;
		logic [4:0] rd;
		logic [6:0] opc;
		logic [11:0] imm;
		f3 = 3'($urandom);
		rd = ($urandom % 4 == 0) ? 5'($urandom) : 5'($urandom % 8); // small set, many waw
		case ($urandom % 10)
			0, 1, 2: word = r_word(((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 0) ?
				7'h20 : 7'h00, f3, rd);
			3, 4, 5: begin
				imm = 12'($urandom);
				if (f3 == 3'd1)
					imm[11:5] = 7'h00; // legal slli
				if (f3 == 3'd5)
					imm[11:5] = ($urandom % 2 == 0) ? 7'h20 : 7'h00;
				word = i_word(imm, f3, rd);
			end
			6: word = {20'($urandom), rd, opc_lui};
			7, 8: word = r_word(7'h01, f3, rd);
			default: begin
				opc = 7'($urandom);
				if (opc inside {opc_op, opc_op_imm, opc_lui})
					opc = opc ^ 7'h08; // lands on an opcode the slice rejects
				word = {25'($urandom), opc};
			end
		endcase
	endtask

	task automatic record_expected(input logic [31:0] word, input logic [31:0] a,
		input logic [31:0] b, input logic [3:0] tag);
		logic [32:0] res;
		res = expected_result(word, a, b);
		if (res[32] || word[11:7] != 5'd0) begin // x0 only written by illegal words
			exp_valid[tag] = 1'b1;
			exp_rd[tag] = word[11:7];
			exp_data[tag] = res[31:0];
			exp_illegal[tag] = res[32];
			order_q[word[11:7]].push_back(tag);
			issue_q.push_back(tag);
		end
	endtask

	// called on a rising edge, returns on the edge of the transfer
	task automatic issue_inst(input logic [31:0] word, input logic [31:0] a,
		input logic [31:0] b);
		int cnt;
		cnt = 0;
		while (exp_valid[next_tag]) begin // tag still in flight
			inst_valid <= 1'b0;
			@(posedge clk);
			cnt++;
			if (cnt > wait_limit)
				stop_with_fail("a tag never came back from writeback");
		end
		inst <= word;
		rs1_val <= a;
		rs2_val <= b;
		inst_id <= next_tag;
		inst_valid <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > wait_limit)
				stop_with_fail("an instruction was never accepted");
			if (!inst_ready && word[6:0] == opc_op && word[31:25] == 7'h01)
				md_stalls++;
		end while (!inst_ready);
		record_expected(word, a, b, next_tag);
		next_tag = next_tag + 4'd1;
	endtask

	always @(negedge clk) begin : wb_checker // mid cycle, outputs settled
		logic [3:0] t;
		int idx;
		if (!reset && wb_valid) begin
			t = wb_inst_id;
			if (!exp_valid[t])
				stop_with_fail("a writeback carried a tag with no outstanding instruction");
			check_value("wb_rd_id", 32'(wb_rd_id), 32'(exp_rd[t]));
			check_value("wb_data", wb_data, exp_data[t]);
			check_value("wb_illegal", 32'(wb_illegal), 32'(exp_illegal[t]));
			check_value("wb_inst_id", 32'(t), 32'(order_q[wb_rd_id][0])); // same rd in order
			void'(order_q[wb_rd_id].pop_front());
			idx = 0;
			for (int i = 0; i < issue_q.size(); i++)
				if (issue_q[i] == t)
					idx = i;
			if (idx != 0)
				overtakes++; // passed an older instruction
			issue_q.delete(idx);
			exp_valid[t] = 1'b0;
			wb_count++;
		end
	end

	initial begin
		int cnt;
		logic [31:0] word;
		void'($urandom(7));
		reset = 1'b1;
		inst = '0;
		rs1_val = '0;
		rs2_val = '0;
		inst_id = '0;
		inst_valid = 1'b0;
		next_tag = '0;
		for (int i = 0; i < 16; i++)
			exp_valid[i] = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		for (int op = 0; op < 8; op++) begin // every m op, random, x/0, overflow
			issue_inst(r_word(7'h01, 3'(op), 5'd9), pick_operand(), pick_operand());
			issue_inst(r_word(7'h01, 3'(op), 5'd10), pick_operand(), 32'h0);
			issue_inst(r_word(7'h01, 3'(op), 5'd11), 32'h8000_0000, 32'hffff_ffff);
		end
		issue_inst(r_word(7'h01, 3'd4, 5'd12), 32'd1000, 32'd7); // long divide
		issue_inst(r_word(7'h00, 3'd0, 5'd13), 32'd5, 32'd6); // these finish first
		issue_inst(r_word(7'h20, 3'd5, 5'd14), 32'h8000_0010, 32'd4);
		issue_inst({20'habcde, 5'd15, opc_lui}, 32'd0, 32'd0);
		issue_inst(i_word(12'hfff, 3'd4, 5'd16), 32'h1234_5678, 32'd0);
		issue_inst(r_word(7'h01, 3'd0, 5'd7), 32'd3, 32'd9); // same rd back to back
		issue_inst(r_word(7'h00, 3'd0, 5'd7), 32'd1, 32'd2);
		issue_inst(i_word(12'h001, 3'd0, 5'd7), 32'd40, 32'd0);
		issue_inst(i_word(12'h005, 3'd0, 5'd0), 32'd1, 32'd0); // x0, no writeback
		issue_inst(r_word(7'h01, 3'd0, 5'd0), 32'd3, 32'd3);
		issue_inst(32'hffff_ffff, 32'd0, 32'd0); // illegal words
		issue_inst(r_word(7'h20, 3'd1, 5'd20), 32'd1, 32'd1);
		issue_inst(32'h0000_0000, 32'd0, 32'd0);
		for (int n = 0; n < random_count; n++) begin
			random_inst(word);
			issue_inst(word, pick_operand(), pick_operand());
		end
		inst_valid <= 1'b0;

		cnt = 0;
		while (issue_q.size() != 0) begin // drain
			@(posedge clk);
			cnt++;
			if (cnt > wait_limit)
				stop_with_fail("writebacks were still missing at the end of the run");
		end
		repeat (4) @(posedge clk); // quiet tail, a stray writeback still trips the checker
		if (md_stalls == 0 || overtakes == 0)
			stop_with_fail("no muldiv stall or no out of order writeback was seen");
		else begin
			$display("%0d writebacks checked", wb_count);
			$display("Everything OK");
			$finish;
		end
	end
endmodule
